// File: verilog/conv_settings.svh
// sizes for the 64-slot convolution engine; kernels wider than CONV_LANES are not supported
`ifndef CONV_SETTINGS_SVH
`define CONV_SETTINGS_SVH

// pixel and weight width, signed
`define CONV_PIX_W 8

// pixels per fetched row segment
`define CONV_LANES 8

// multipliers in the MAC array
`define CONV_SLOTS 64

// one group per output column in a batch, at most
`define CONV_MAX_GROUPS 8

// image and kernel dimensions, positions
`define CONV_DIM_W 8

// per-group sum width
`define CONV_ACC_W 32

`endif

// File: verilog/conv_geom_pkg.sv
// geometry is unsigned and must stay stable for a whole job
`include "conv_settings.svh"
`default_nettype none

package conv_geom_pkg;

    // job geometry, 32 bits
    typedef struct packed {
        logic [`CONV_DIM_W-1:0] img_rows;
        logic [`CONV_DIM_W-1:0] img_cols;
        logic [`CONV_DIM_W-1:0] ker_rows;
        logic [`CONV_DIM_W-1:0] ker_cols;
    } geom_t;

    // output position, top left of the window
    typedef struct packed {
        logic [`CONV_DIM_W-1:0] row;
        logic [`CONV_DIM_W-1:0] col;
    } pos_t;

    // 0 to 8 groups
    typedef logic [$clog2(`CONV_MAX_GROUPS+1)-1:0] grp_cnt_t;

endpackage

`default_nettype wire

// File: verilog/mac_lane_pkg.sv
// all lane and slot values are signed two's complement, lane 0 in the low bits
`include "conv_settings.svh"
`default_nettype none

package mac_lane_pkg;

    typedef logic signed [`CONV_PIX_W-1:0] pixel_t;

    // one row segment, lane 0 first
    typedef pixel_t [`CONV_LANES-1:0] lane_vec_t;

    // one fetched beat
    typedef struct packed {
        lane_vec_t pixels;
        // lanes at or above ker_cols are don't care
        lane_vec_t weights;
        logic [`CONV_DIM_W-1:0] krow;
        conv_geom_pkg::grp_cnt_t groups;
    } beat_t;

    // operand vector for all multipliers
    typedef pixel_t [`CONV_SLOTS-1:0] slot_vec_t;

    typedef logic signed [`CONV_ACC_W-1:0] acc_t;

    // one sum per group, group 0 in the low bits
    typedef acc_t [`CONV_MAX_GROUPS-1:0] group_sums_t;

endpackage

`default_nettype wire

// File: verilog/window_sequencer.sv
// one fetch outstanding; fetch_pos_o is the output position, image row is its row plus krow
`timescale 1ns/1ps
`include "conv_settings.svh"
`default_nettype none

module window_sequencer (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     start_i,
    input  conv_geom_pkg::geom_t     geom_i,
    input  logic                     beat_valid_i,
    input  mac_lane_pkg::beat_t      beat_i,
    output logic                     fetch_req_o,
    output conv_geom_pkg::pos_t      fetch_pos_o,
    output logic [`CONV_DIM_W-1:0]   fetch_krow_o,
    output logic                     beat_valid_o,
    output mac_lane_pkg::beat_t      beat_o,
    output logic                     batch_valid_o,
    output conv_geom_pkg::pos_t      batch_pos_o,
    output conv_geom_pkg::grp_cnt_t  batch_groups_o,
    output logic                     batch_last_o
);
    conv_geom_pkg::pos_t     pos_q;
    conv_geom_pkg::grp_cnt_t groups;
    logic [`CONV_DIM_W-1:0]  krow_q;
    logic [`CONV_DIM_W-1:0]  out_rows;
    logic [`CONV_DIM_W-1:0]  out_cols;
    logic [`CONV_DIM_W-1:0]  cols_left;
    logic [`CONV_DIM_W-1:0]  lane_room;
    logic [`CONV_DIM_W-1:0]  grp_w;
    logic [15:0]             area;
    logic [3:0]              fit_area;
    logic                    pend_q;
    logic                    take;
    logic                    last_krow;
    logic                    row_wrap;
    logic                    job_end;
    logic                    batch_end;

    // valid convolution output size
    assign out_rows  = geom_i.img_rows - geom_i.ker_rows + 1'b1;
    assign out_cols  = geom_i.img_cols - geom_i.ker_cols + 1'b1;
    assign cols_left = out_cols - pos_q.col;
    assign area      = geom_i.ker_rows * geom_i.ker_cols;
    // a group needs ker_cols neighbouring lanes of the segment
    assign lane_room = `CONV_DIM_W'(`CONV_LANES + 1) - geom_i.ker_cols;

    // largest g with g * area inside the slots
    always_comb begin
        fit_area = '0;
        for (int g = 1; g <= `CONV_MAX_GROUPS; g++) begin
            if (g * area <= `CONV_SLOTS) begin
                fit_area = 4'(g);
            end
        end
    end

    // smallest of the three limits
    always_comb begin
        grp_w = {4'd0, fit_area};
        if (lane_room < grp_w) begin
            grp_w = lane_room;
        end
        if (cols_left < grp_w) begin
            grp_w = cols_left;
        end
    end
    assign groups = grp_w[3:0];

    assign take      = beat_valid_i && fetch_req_o;
    assign last_krow = krow_q == geom_i.ker_rows - 1'b1;
    // groups never exceed cols_left, so equality ends the row
    assign row_wrap  = {4'd0, groups} == cols_left;
    assign job_end   = row_wrap && (pos_q.row == out_rows - 1'b1);
    assign batch_end = take && last_krow;

    always_ff @(posedge clk) begin
        if (!rst) begin
            fetch_req_o   <= 1'b0;
            pend_q        <= 1'b0;
            pos_q         <= '0;
            krow_q        <= '0;
            batch_valid_o <= 1'b0;
        end else begin
            batch_valid_o <= batch_end;
            if (start_i) begin
                fetch_req_o <= 1'b1;
                pend_q      <= 1'b0;
                pos_q       <= '0;
                krow_q      <= '0;
            end else if (take) begin
                // request drops for one cycle after every beat
                fetch_req_o <= 1'b0;
                pend_q      <= !(last_krow && job_end);
                krow_q      <= last_krow ? '0 : krow_q + 1'b1;
                if (last_krow && row_wrap) begin
                    pos_q.row <= pos_q.row + 1'b1;
                    pos_q.col <= '0;
                end else if (last_krow) begin
                    pos_q.col <= pos_q.col + groups;
                end
            end else if (pend_q) begin
                fetch_req_o <= 1'b1;
                pend_q      <= 1'b0;
            end
        end
    end

    // descriptor of the batch just completed
    always_ff @(posedge clk) begin
        if (batch_end) begin
            batch_pos_o    <= pos_q;
            batch_groups_o <= groups;
            batch_last_o   <= job_end;
        end
    end

    assign fetch_pos_o  = pos_q;
    assign fetch_krow_o = krow_q;

    // beat forwarded in the same cycle, tagged with row and group count
    always_comb begin
        beat_o        = beat_i;
        beat_o.krow   = krow_q;
        beat_o.groups = groups;
    end
    assign beat_valid_o = take;

    a_geom_fits: assert property (@(posedge clk) disable iff (!rst)
        start_i |-> (geom_i.ker_cols <= `CONV_LANES && area <= `CONV_SLOTS))
        else $error("kernel does not fit the lanes or the slots");

    a_beat_in_req: assert property (@(posedge clk) disable iff (!rst)
        beat_valid_i |-> fetch_req_o)
        else $error("beat without an open fetch request");

endmodule

`default_nettype wire

// File: verilog/image_lane_packer.sv
// expects groups <= 9 - ker_cols so every group reads inside the 8-lane segment
`timescale 1ns/1ps
`include "conv_settings.svh"
`default_nettype none

module image_lane_packer (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     beat_valid_i,
    input  mac_lane_pkg::beat_t      beat_i,
    input  logic [`CONV_DIM_W-1:0]   ker_rows_i,
    input  logic [`CONV_DIM_W-1:0]   ker_cols_i,
    output logic                     slot_valid_o,
    output mac_lane_pkg::slot_vec_t  slots_o
);
    conv_geom_pkg::grp_cnt_t  grp;
    mac_lane_pkg::slot_vec_t  slots_d;
    logic [15:0]              k_area;
    logic                     last_row;

    // slots per group
    assign k_area   = ker_rows_i * ker_cols_i;
    assign last_row = beat_i.krow == ker_rows_i - 1'b1;
    assign grp      = beat_i.groups;

    always_comb begin
        int unsigned idx;
        // fresh vector on the first kernel row
        slots_d = (beat_i.krow == '0) ? '0 : slots_o;
        for (int g = 0; g < `CONV_MAX_GROUPS; g++) begin
            for (int c = 0; c < `CONV_LANES; c++) begin
                idx = g * k_area + beat_i.krow * ker_cols_i + c;
                // group g starts at lane g, shifted window
                if (g < grp && c < ker_cols_i && g + c < `CONV_LANES
                        && idx < `CONV_SLOTS) begin
                    slots_d[idx] = beat_i.pixels[g + c];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (beat_valid_i) begin
            slots_o <= slots_d;
        end
    end

    // full vector after the last kernel row
    always_ff @(posedge clk) begin
        if (!rst) begin
            slot_valid_o <= 1'b0;
        end else begin
            slot_valid_o <= beat_valid_i && last_row;
        end
    end

endmodule

`default_nettype wire

// File: verilog/kernel_lane_packer.sv
// weights in lanes 0 to ker_cols-1 only; kernel copied once per group of the batch
`timescale 1ns/1ps
`include "conv_settings.svh"
`default_nettype none

module kernel_lane_packer (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     beat_valid_i,
    input  mac_lane_pkg::beat_t      beat_i,
    input  logic [`CONV_DIM_W-1:0]   ker_rows_i,
    input  logic [`CONV_DIM_W-1:0]   ker_cols_i,
    output logic                     slot_valid_o,
    output mac_lane_pkg::slot_vec_t  slots_o
);
    conv_geom_pkg::grp_cnt_t  grp;
    mac_lane_pkg::slot_vec_t  slots_d;
    logic [15:0]              k_area;

    assign k_area = ker_rows_i * ker_cols_i;
    assign grp    = beat_i.groups;

    always_comb begin
        int unsigned idx;
        slots_d = (beat_i.krow == '0) ? '0 : slots_o;
        for (int g = 0; g < `CONV_MAX_GROUPS; g++) begin
            for (int c = 0; c < `CONV_LANES; c++) begin
                idx = g * k_area + beat_i.krow * ker_cols_i + c;
                // same weight lane for every group
                if (g < grp && c < ker_cols_i && idx < `CONV_SLOTS) begin
                    slots_d[idx] = beat_i.weights[c];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (beat_valid_i) begin
            slots_o <= slots_d;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            slot_valid_o <= 1'b0;
        end else begin
            slot_valid_o <= beat_valid_i && (beat_i.krow == ker_rows_i - 1'b1);
        end
    end

    // every beat carries a row inside the kernel so the last row always comes
    a_krow_in_kernel: assert property (@(posedge clk) disable iff (!rst)
        beat_valid_i |-> (beat_i.krow < ker_rows_i))
        else $error("beat kernel row beyond the kernel height");

endmodule

`default_nettype wire

// File: verilog/group_mac_array.sv
// group g owns slots g*K to g*K+K-1 with K = ker_rows * ker_cols; no output stall
`timescale 1ns/1ps
`include "conv_settings.svh"
`default_nettype none

module group_mac_array (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       img_valid_i,
    input  mac_lane_pkg::slot_vec_t    img_slots_i,
    input  mac_lane_pkg::slot_vec_t    wgt_slots_i,
    input  logic [`CONV_DIM_W-1:0]     ker_rows_i,
    input  logic [`CONV_DIM_W-1:0]     ker_cols_i,
    input  conv_geom_pkg::pos_t        batch_pos_i,
    input  conv_geom_pkg::grp_cnt_t    batch_groups_i,
    input  logic                       batch_last_i,
    output logic                       result_valid_o,
    output mac_lane_pkg::group_sums_t  result_o,
    output conv_geom_pkg::pos_t        result_pos_o,
    output conv_geom_pkg::grp_cnt_t    result_groups_o,
    output logic                       done_o
);
    mac_lane_pkg::group_sums_t  sums;
    logic [15:0]                k_area;

    assign k_area = ker_rows_i * ker_cols_i;

    // signed products summed per group, idle groups stay zero
    always_comb begin
        int unsigned idx;
        sums = '0;
        for (int g = 0; g < `CONV_MAX_GROUPS; g++) begin
            for (int k = 0; k < `CONV_SLOTS; k++) begin
                idx = g * k_area + k;
                if (g < batch_groups_i && k < k_area && idx < `CONV_SLOTS) begin
                    sums[g] = sums[g] + mac_lane_pkg::acc_t'(img_slots_i[idx])
                        * mac_lane_pkg::acc_t'(wgt_slots_i[idx]);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (img_valid_i) begin
            result_o        <= sums;
            result_pos_o    <= batch_pos_i;
            result_groups_o <= batch_groups_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            result_valid_o <= 1'b0;
            done_o         <= 1'b0;
        end else begin
            result_valid_o <= img_valid_i;
            // done rides with the last result
            done_o         <= img_valid_i && batch_last_i;
        end
    end

    a_groups_range: assert property (@(posedge clk) disable iff (!rst)
        img_valid_i |-> (batch_groups_i inside {[1:`CONV_MAX_GROUPS]}))
        else $error("batch group count out of range");

endmodule

`default_nettype wire

// File: verilog/conv_group_engine.sv
// geom_i must hold from start_i to done_o; result_valid_o is a one-cycle pulse, no stall
`timescale 1ns/1ps
`include "conv_settings.svh"
`default_nettype none

module conv_group_engine (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       start_i,
    input  conv_geom_pkg::geom_t       geom_i,
    input  logic                       beat_valid_i,
    input  mac_lane_pkg::beat_t        beat_i,
    output logic                       fetch_req_o,
    output conv_geom_pkg::pos_t        fetch_pos_o,
    output logic [`CONV_DIM_W-1:0]     fetch_krow_o,
    output logic                       result_valid_o,
    output mac_lane_pkg::group_sums_t  result_o,
    output conv_geom_pkg::pos_t        result_pos_o,
    output conv_geom_pkg::grp_cnt_t    result_groups_o,
    output logic                       done_o
);
    mac_lane_pkg::beat_t        seq_beat;
    mac_lane_pkg::slot_vec_t    img_slots;
    mac_lane_pkg::slot_vec_t    wgt_slots;
    conv_geom_pkg::pos_t        batch_pos;
    conv_geom_pkg::grp_cnt_t    batch_groups;
    logic                       seq_beat_valid;
    logic                       batch_valid;
    logic                       batch_last;
    logic                       img_slot_valid;
    logic                       wgt_slot_valid;

    window_sequencer window_sequencer_i (
        .clk(clk), .rst(rst), .start_i(start_i), .geom_i(geom_i),
        .beat_valid_i(beat_valid_i), .beat_i(beat_i),
        .fetch_req_o(fetch_req_o), .fetch_pos_o(fetch_pos_o), .fetch_krow_o(fetch_krow_o),
        .beat_valid_o(seq_beat_valid), .beat_o(seq_beat),
        .batch_valid_o(batch_valid), .batch_pos_o(batch_pos),
        .batch_groups_o(batch_groups), .batch_last_o(batch_last)
    );

    // both packers see the same tagged beat
    image_lane_packer image_lane_packer_i (
        .clk(clk), .rst(rst), .beat_valid_i(seq_beat_valid), .beat_i(seq_beat),
        .ker_rows_i(geom_i.ker_rows), .ker_cols_i(geom_i.ker_cols),
        .slot_valid_o(img_slot_valid), .slots_o(img_slots)
    );

    kernel_lane_packer kernel_lane_packer_i (
        .clk(clk), .rst(rst), .beat_valid_i(seq_beat_valid), .beat_i(seq_beat),
        .ker_rows_i(geom_i.ker_rows), .ker_cols_i(geom_i.ker_cols),
        .slot_valid_o(wgt_slot_valid), .slots_o(wgt_slots)
    );

    group_mac_array group_mac_array_i (
        .clk(clk), .rst(rst), .img_valid_i(img_slot_valid),
        .img_slots_i(img_slots), .wgt_slots_i(wgt_slots),
        .ker_rows_i(geom_i.ker_rows), .ker_cols_i(geom_i.ker_cols),
        .batch_pos_i(batch_pos), .batch_groups_i(batch_groups), .batch_last_i(batch_last),
        .result_valid_o(result_valid_o), .result_o(result_o), .result_pos_o(result_pos_o),
        .result_groups_o(result_groups_o), .done_o(done_o)
    );

    // packers and batch descriptor must line up cycle for cycle
    a_batch_aligned: assert property (@(posedge clk) disable iff (!rst)
        (batch_valid == img_slot_valid) && (img_slot_valid == wgt_slot_valid))
        else $error("slot vectors and batch descriptor out of step");

endmodule

`default_nettype wire

// File: verification/conv_group_engine_tb.sv
// feeder answers after 0 to 3 idle cycles; image lanes past the right edge read zero
`timescale 1ns/1ps
`include "conv_settings.svh"
`default_nettype none

module conv_group_engine_tb;

    // one table row, geometry then expected batch count
    typedef struct packed {
        conv_geom_pkg::geom_t geom;
        logic [7:0]           batches;
    } job_t;

    logic                       clk;
    logic                       rst;
    logic                       start_i;
    conv_geom_pkg::geom_t       geom_i;
    logic                       beat_valid_i;
    mac_lane_pkg::beat_t        beat_i;
    logic                       fetch_req_o;
    conv_geom_pkg::pos_t        fetch_pos_o;
    logic [`CONV_DIM_W-1:0]     fetch_krow_o;
    logic                       result_valid_o;
    mac_lane_pkg::group_sums_t  result_o;
    conv_geom_pkg::pos_t        result_pos_o;
    conv_geom_pkg::grp_cnt_t    result_groups_o;
    logic                       done_o;

    job_t                  jobs [6];
    logic signed [7:0]     img_mem [256];
    logic signed [7:0]     ker_mem [64];
    conv_geom_pkg::geom_t  cur;
    int                    cycle_cnt = 0;
    int                    err_cnt;
    int                    exp_row;
    int                    exp_col;
    int                    exp_krow;
    int                    exp_fetch_row;
    int                    exp_fetch_col;
    int                    result_cnt;
    bit                    job_active;
    bit                    done_seen;
    // cycle of each last-kernel-row beat, oldest first
    int                    last_beat_q [$];

    conv_group_engine conv_group_engine_i (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    task automatic compare_value(input string name, input longint expected,
                                 input longint actual);
        if (expected != actual) begin
            err_cnt++;
            $display("ERROR at %0t ns: %s expected %0d, got %0d", $time, name, expected, actual);
            $display("Done: errors found");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    task automatic stop_with_failure(input string what);
        $display("FAILURE at %0t ns: %s", $time, what);
        $display("Done: errors found");
        $fatal(1, "stopped on a failure");
    endtask

    // direct sum over the kernel window at output (r, c)
    function automatic longint ref_sum(input int r, input int c);
        longint s;
        s = 0;
        for (int kr = 0; kr < int'(cur.ker_rows); kr++) begin
            for (int kc = 0; kc < int'(cur.ker_cols); kc++) begin
                s += img_mem[(r + kr) * cur.img_cols + c + kc]
                    * ker_mem[kr * cur.ker_cols + kc];
            end
        end
        return s;
    endfunction

    // slots per area, lanes left after one kernel width, columns left in the row
    function automatic int expected_groups(input int col);
        int kr;
        int kc;
        int g;
        kr = cur.ker_rows;
        kc = cur.ker_cols;
        g = `CONV_SLOTS / (kr * kc);
        if (`CONV_LANES + 1 - kc < g) begin
            g = `CONV_LANES + 1 - kc;
        end
        if (int'(cur.img_cols) - kc + 1 - col < g) begin
            g = int'(cur.img_cols) - kc + 1 - col;
        end
        return g;
    endfunction

    task automatic check_result();
        int groups;
        int out_rows;
        int out_cols;
        int beat_cyc;
        out_rows = int'(cur.img_rows) - int'(cur.ker_rows) + 1;
        out_cols = int'(cur.img_cols) - int'(cur.ker_cols) + 1;
        if (last_beat_q.size() == 0) begin
            stop_with_failure("a result came without a beat for the last kernel row");
        end
        beat_cyc = last_beat_q.pop_front();
        compare_value("result_valid_o latency", 2, cycle_cnt - beat_cyc);
        compare_value("result_pos_o.row", exp_row, result_pos_o.row);
        compare_value("result_pos_o.col", exp_col, result_pos_o.col);
        groups = expected_groups(exp_col);
        compare_value("result_groups_o", groups, result_groups_o);
        // idle groups must read zero
        for (int g = 0; g < `CONV_MAX_GROUPS; g++) begin
            compare_value($sformatf("result_o[%0d]", g),
                g < groups ? ref_sum(exp_row, exp_col + g) : 0, result_o[g]);
        end
        result_cnt++;
        // row-major stepping by the group count
        exp_col += groups;
        if (exp_col >= out_cols) begin
            exp_col = 0;
            exp_row++;
        end
        compare_value("done_o", exp_row == out_rows, done_o);
        if (done_o) begin
            done_seen = 1'b1;
        end
    endtask

    // outputs are sampled mid-cycle, away from the driving edge
    always @(negedge clk) begin
        if (rst && !job_active) begin
            compare_value("fetch_req_o", 0, fetch_req_o);
            compare_value("result_valid_o", 0, result_valid_o);
            compare_value("done_o", 0, done_o);
        end
        if (job_active && beat_valid_i && fetch_req_o) begin
            compare_value("fetch_krow_o", exp_krow, fetch_krow_o);
            compare_value("fetch_pos_o.row", exp_fetch_row, fetch_pos_o.row);
            compare_value("fetch_pos_o.col", exp_fetch_col, fetch_pos_o.col);
            if (exp_krow == int'(cur.ker_rows) - 1) begin
                last_beat_q.push_back(cycle_cnt);
                exp_krow = 0;
                // next batch starts one group count further on
                exp_fetch_col += expected_groups(exp_fetch_col);
                if (exp_fetch_col >= int'(cur.img_cols) - int'(cur.ker_cols) + 1) begin
                    exp_fetch_col = 0;
                    exp_fetch_row++;
                end
            end else begin
                exp_krow++;
            end
        end
        if (job_active && result_valid_o) begin
            check_result();
        end else if (job_active) begin
            compare_value("done_o", 0, done_o);
        end
    end

    // one beat for the open request
    task automatic serve_fetch();
        int row;
        int delay;
        mac_lane_pkg::beat_t b;
        delay = $urandom_range(3, 0);
        repeat (delay) @(posedge clk);
        row = fetch_pos_o.row + fetch_krow_o;
        b = '0;
        for (int l = 0; l < `CONV_LANES; l++) begin
            if (fetch_pos_o.col + l < cur.img_cols) begin
                b.pixels[l] = img_mem[row * cur.img_cols + fetch_pos_o.col + l];
            end
            // junk above ker_cols, must not reach a sum
            b.weights[l] = (l < cur.ker_cols) ? ker_mem[fetch_krow_o * cur.ker_cols + l]
                                              : $urandom;
        end
        // tag fields are overwritten inside the DUT
        b.krow = $urandom;
        b.groups = $urandom;
        beat_valid_i <= 1'b1;
        beat_i <= b;
        @(posedge clk);
        beat_valid_i <= 1'b0;
    endtask

    initial begin
        int   wait_cnt;
        job_t job;
        rst = 1'b0;
        start_i = 1'b0;
        geom_i = '0;
        beat_valid_i = 1'b0;
        beat_i = '0;
        err_cnt = 0;
        job_active = 1'b0;
        done_seen = 1'b0;
        void'($urandom(32'h40ee_524e));
        // img_rows, img_cols, ker_rows, ker_cols, batches
        jobs[0] = {8'd6, 8'd6, 8'd3, 8'd3, 8'd4};
        jobs[1] = {8'd10, 8'd10, 8'd2, 8'd2, 8'd18};
        jobs[2] = {8'd8, 8'd12, 8'd1, 8'd8, 8'd40};
        jobs[3] = {8'd9, 8'd9, 8'd8, 8'd8, 8'd4};
        jobs[4] = {8'd5, 8'd7, 8'd5, 8'd1, 8'd1};
        jobs[5] = {8'd3, 8'd3, 8'd3, 8'd3, 8'd1};
        repeat (4) @(posedge clk);
        rst <= 1'b1;
        // idle stretch, outputs must stay low
        repeat (3) @(posedge clk);
        foreach (jobs[j]) begin
            job = jobs[j];
            foreach (img_mem[a]) begin
                img_mem[a] = $urandom;
            end
            foreach (ker_mem[a]) begin
                ker_mem[a] = $urandom;
            end
            @(posedge clk);
            geom_i <= job.geom;
            cur = job.geom;
            exp_row = 0;
            exp_col = 0;
            exp_krow = 0;
            exp_fetch_row = 0;
            exp_fetch_col = 0;
            result_cnt = 0;
            done_seen = 1'b0;
            last_beat_q.delete();
            @(posedge clk);
            start_i <= 1'b1;
            job_active = 1'b1;
            @(posedge clk);
            start_i <= 1'b0;
            wait_cnt = 0;
            while (!done_seen) begin
                @(posedge clk);
                wait_cnt++;
                if (wait_cnt > 40) begin
                    stop_with_failure("no fetch request and no done_o within 40 cycles");
                end
                if (fetch_req_o) begin
                    serve_fetch();
                    wait_cnt = 0;
                end
            end
            job_active = 1'b0;
            compare_value("result count", job.batches, result_cnt);
        end
        if (err_cnt == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: conv_group_engine.f
+incdir+verilog
verilog/conv_geom_pkg.sv
verilog/mac_lane_pkg.sv
verilog/window_sequencer.sv
verilog/image_lane_packer.sv
verilog/kernel_lane_packer.sv
verilog/group_mac_array.sv
verilog/conv_group_engine.sv
verification/conv_group_engine_tb.sv

// File: Bender.yml
package:
  name: conv_group_engine

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/conv_geom_pkg.sv
      - verilog/mac_lane_pkg.sv
      - verilog/window_sequencer.sv
      - verilog/image_lane_packer.sv
      - verilog/kernel_lane_packer.sv
      - verilog/group_mac_array.sv
      - verilog/conv_group_engine.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - verification/conv_group_engine_tb.sv
